//--- compile.f
hw/mem_pkg.sv
hw/load_issue.sv
hw/data_ram.sv
hw/resp_capture.sv
hw/load_align.sv
hw/mem_stage.sv
tb/mem_stage_properties.sv
tb/mem_stage_tb.sv

//--- hw/data_ram.sv
`default_nettype none

module data_ram #(
    parameter int fast_latency = 1,
    parameter int slow_latency = 3
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             req_valid_0,
    input  mem_pkg::word_t   req_addr_0,
    input  mem_pkg::word_t   req_wdata_0,
    input  mem_pkg::strobe_t req_strobe_0,
    input  logic             req_write_0,
    input  logic             req_valid_1,
    input  mem_pkg::word_t   req_addr_1,
    input  mem_pkg::word_t   req_wdata_1,
    input  mem_pkg::strobe_t req_strobe_1,
    input  logic             req_write_1,
    output logic             resp_ok0,
    output logic             resp_ok1,
    output mem_pkg::word_t   resp_data0,
    output mem_pkg::word_t   resp_data1
);
    import mem_pkg::*;

    // wide enough for latencies up to 7
    localparam int cnt_w = 3;
    localparam int depth = 2 ** addr_idx_w;

    word_t                 mem [depth];
    logic [addr_idx_w-1:0] idx0;
    logic [addr_idx_w-1:0] idx1;
    logic                  wr0;
    logic                  wr1;
    word_t                 rd0;
    word_t                 rd1;
    logic [cnt_w-1:0]      cnt0;
    logic [cnt_w-1:0]      cnt1;
    word_t                 data0_q;
    word_t                 data1_q;

    function automatic word_t merge(word_t old, word_t data, strobe_t strobe);
        word_t res;
        res = old;
        for (int b = 0; b < $bits(strobe_t); b++) begin
            if (strobe[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [cnt_w-1:0] start_count(word_t addr);
        return addr[uncached_bit] ? cnt_w'(slow_latency) : cnt_w'(fast_latency);
    endfunction

    assign idx0 = req_addr_0[addr_idx_w+1:2];
    assign idx1 = req_addr_1[addr_idx_w+1:2];
    assign wr0  = req_valid_0 && req_write_0;
    assign wr1  = req_valid_1 && req_write_1;

    // lane 1 sees a same-cycle lane 0 store, lane 0 never sees lane 1
    always_comb begin
        rd0 = mem[idx0];
        rd1 = mem[idx1];
        if (wr0 && idx0 == idx1) begin
            rd1 = merge(rd1, req_wdata_0, req_strobe_0);
        end
    end

    // lane 1 builds on rd1, so a shared word keeps both lanes' bytes
    always_ff @(posedge clk) begin
        if (wr0) begin
            mem[idx0] <= merge(rd0, req_wdata_0, req_strobe_0);
        end
        if (wr1) begin
            mem[idx1] <= merge(rd1, req_wdata_1, req_strobe_1);
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            cnt0 <= '0;
            cnt1 <= '0;
        end else begin
            if (req_valid_0) begin
                cnt0 <= start_count(req_addr_0);
            end else if (cnt0 != '0) begin
                cnt0 <= cnt0 - 1'b1;
            end
            if (req_valid_1) begin
                cnt1 <= start_count(req_addr_1);
            end else if (cnt1 != '0) begin
                cnt1 <= cnt1 - 1'b1;
            end
        end
    end

    // read data is sampled at request time and waits out the latency
    always_ff @(posedge clk) begin
        if (req_valid_0) begin
            data0_q <= rd0;
        end
        if (req_valid_1) begin
            data1_q <= rd1;
        end
    end

    assign resp_ok0   = cnt0 == cnt_w'(1);
    assign resp_ok1   = cnt1 == cnt_w'(1);
    assign resp_data0 = data0_q;
    assign resp_data1 = data1_q;

endmodule

`default_nettype wire

//--- hw/load_align.sv
`default_nettype none

module load_align (
    input  mem_pkg::word_t  raw,
    input  logic [1:0]      off,
    input  mem_pkg::msize_t size,
    input  logic            sext,
    output mem_pkg::word_t  rdata
);
    import mem_pkg::*;

    word_t shifted;
    logic  byte_sign;
    logic  half_sign;

    // bring the addressed byte down to bit 0
    assign shifted = raw >> {off, 3'b000};

    // sign bits only count for signed loads
    assign byte_sign = sext && shifted[7];
    assign half_sign = sext && shifted[15];

    always_comb begin
        case (size)
            sz_byte: begin
                rdata = {{24{byte_sign}}, shifted[7:0]};
            end
            sz_half: begin
                rdata = {{16{half_sign}}, shifted[15:0]};
            end
            default: begin
                rdata = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/load_issue.sv
`default_nettype none

module load_issue (
    input  logic             clk,
    input  logic             resetn,
    input  logic             in_valid,
    output logic             in_ready,
    input  mem_pkg::mem_op_t op0,
    input  mem_pkg::mem_op_t op1,
    input  mem_pkg::msize_t  size0,
    input  mem_pkg::msize_t  size1,
    input  logic             sext0,
    input  logic             sext1,
    input  mem_pkg::word_t   addr0,
    input  mem_pkg::word_t   addr1,
    input  mem_pkg::word_t   wdata0,
    input  mem_pkg::word_t   wdata1,
    input  logic             pair_done,
    output logic             req_valid_0,
    output mem_pkg::word_t   req_addr_0,
    output mem_pkg::word_t   req_wdata_0,
    output mem_pkg::strobe_t req_strobe_0,
    output logic             req_write_0,
    output logic             req_valid_1,
    output mem_pkg::word_t   req_addr_1,
    output mem_pkg::word_t   req_wdata_1,
    output mem_pkg::strobe_t req_strobe_1,
    output logic             req_write_1,
    output logic             issue_pulse,
    output logic             lane_need0,
    output logic             lane_need1,
    output mem_pkg::msize_t  ctx_size0,
    output mem_pkg::msize_t  ctx_size1,
    output logic             ctx_sext0,
    output logic             ctx_sext1,
    output logic [1:0]       ctx_off0,
    output logic [1:0]       ctx_off1,
    output mem_pkg::mem_op_t ctx_op0,
    output mem_pkg::mem_op_t ctx_op1,
    output logic             ctx_mis0,
    output logic             ctx_mis1
);
    import mem_pkg::*;

    logic    busy;
    logic    issue_q;
    logic    accept;
    mem_op_t op0_q;
    mem_op_t op1_q;
    msize_t  size0_q;
    msize_t  size1_q;
    logic    sext0_q;
    logic    sext1_q;
    word_t   addr0_q;
    word_t   addr1_q;
    word_t   wdata0_q;
    word_t   wdata1_q;
    logic    mis0_q;
    logic    mis1_q;

    // half needs bit 0 clear, word needs both low bits clear
    function automatic logic misaligned(msize_t size, logic [1:0] off);
        case (size)
            sz_half: return off[0];
            sz_word: return off != 2'b00;
            default: return 1'b0;
        endcase
    endfunction

    function automatic strobe_t lane_strobe(msize_t size, logic [1:0] off);
        case (size)
            sz_byte: return strobe_t'(4'b0001) << off;
            sz_half: return strobe_t'(4'b0011) << off;
            default: return 4'b1111;
        endcase
    endfunction

    // replicate the low bytes so the strobe picks the right lane
    function automatic word_t lane_wdata(msize_t size, word_t data);
        case (size)
            sz_byte: return {4{data[7:0]}};
            sz_half: return {2{data[15:0]}};
            default: return data;
        endcase
    endfunction

    assign in_ready = ~busy;
    assign accept   = in_valid && in_ready;

    // busy from acceptance until the output transfers
    always_ff @(posedge clk) begin
        if (resetn) begin
            busy    <= 1'b0;
            issue_q <= 1'b0;
        end else begin
            issue_q <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (pair_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op0_q    <= op0;
            op1_q    <= op1;
            size0_q  <= size0;
            size1_q  <= size1;
            sext0_q  <= sext0;
            sext1_q  <= sext1;
            addr0_q  <= addr0;
            addr1_q  <= addr1;
            wdata0_q <= wdata0;
            wdata1_q <= wdata1;
            mis0_q   <= (op0 != op_none) && misaligned(size0, addr0[1:0]);
            mis1_q   <= (op1 != op_none) && misaligned(size1, addr1[1:0]);
        end
    end

    // misaligned and pass-through lanes stay off the ram
    assign lane_need0  = (op0_q != op_none) && !mis0_q;
    assign lane_need1  = (op1_q != op_none) && !mis1_q;
    assign issue_pulse = issue_q;

    assign req_valid_0  = issue_q && lane_need0;
    assign req_addr_0   = addr0_q;
    assign req_wdata_0  = lane_wdata(size0_q, wdata0_q);
    assign req_write_0  = op0_q == op_store;
    assign req_strobe_0 = req_write_0 ? lane_strobe(size0_q, addr0_q[1:0]) : '0;

    assign req_valid_1  = issue_q && lane_need1;
    assign req_addr_1   = addr1_q;
    assign req_wdata_1  = lane_wdata(size1_q, wdata1_q);
    assign req_write_1  = op1_q == op_store;
    assign req_strobe_1 = req_write_1 ? lane_strobe(size1_q, addr1_q[1:0]) : '0;

    assign ctx_size0 = size0_q;
    assign ctx_size1 = size1_q;
    assign ctx_sext0 = sext0_q;
    assign ctx_sext1 = sext1_q;
    assign ctx_off0  = addr0_q[1:0];
    assign ctx_off1  = addr1_q[1:0];
    assign ctx_op0   = op0_q;
    assign ctx_op1   = op1_q;
    assign ctx_mis0  = mis0_q;
    assign ctx_mis1  = mis1_q;

endmodule

`default_nettype wire

//--- hw/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // data path and address width
    localparam int word_w = 32;

    // ram word index, 256 words
    localparam int addr_idx_w = 8;

    // address bit that selects the slow, uncached region
    localparam int uncached_bit = 12;

    typedef logic [word_w-1:0] word_t;

    // one enable per byte of a word
    typedef logic [word_w/8-1:0] strobe_t;

    // op_none passes through the stage without touching memory
    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_load  = 2'd1,
        op_store = 2'd2
    } mem_op_t;

    typedef enum logic [1:0] {
        sz_byte = 2'd0,
        sz_half = 2'd1,
        sz_word = 2'd2
    } msize_t;

endpackage

`default_nettype wire

//--- hw/mem_stage.sv
`default_nettype none

module mem_stage #(
    parameter int fast_latency = 1,
    parameter int slow_latency = 3
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             in_valid,
    output logic             in_ready,
    input  mem_pkg::mem_op_t op0,
    input  mem_pkg::mem_op_t op1,
    input  mem_pkg::msize_t  size0,
    input  mem_pkg::msize_t  size1,
    input  logic             sext0,
    input  logic             sext1,
    input  mem_pkg::word_t   addr0,
    input  mem_pkg::word_t   addr1,
    input  mem_pkg::word_t   wdata0,
    input  mem_pkg::word_t   wdata1,
    output logic             out_valid,
    input  logic             out_ready,
    output mem_pkg::word_t   rdata0,
    output mem_pkg::word_t   rdata1,
    output logic             misalign0,
    output logic             misalign1,
    output mem_pkg::mem_op_t op0_out,
    output mem_pkg::mem_op_t op1_out
);
    import mem_pkg::*;

    logic       req_valid_0;
    word_t      req_addr_0;
    word_t      req_wdata_0;
    strobe_t    req_strobe_0;
    logic       req_write_0;
    logic       req_valid_1;
    word_t      req_addr_1;
    word_t      req_wdata_1;
    strobe_t    req_strobe_1;
    logic       req_write_1;
    logic       issue_pulse;
    logic       lane_need0;
    logic       lane_need1;
    msize_t     ctx_size0;
    msize_t     ctx_size1;
    logic       ctx_sext0;
    logic       ctx_sext1;
    logic [1:0] ctx_off0;
    logic [1:0] ctx_off1;
    mem_op_t    ctx_op0;
    mem_op_t    ctx_op1;
    logic       ctx_mis0;
    logic       ctx_mis1;
    logic       resp_ok0;
    logic       resp_ok1;
    word_t      resp_data0;
    word_t      resp_data1;
    logic       pair_done;
    word_t      held_data0;
    word_t      held_data1;
    word_t      aligned0;
    word_t      aligned1;

    load_issue u_issue (
        .clk(clk), .resetn(resetn), .in_valid(in_valid), .in_ready(in_ready),
        .op0(op0), .op1(op1), .size0(size0), .size1(size1),
        .sext0(sext0), .sext1(sext1), .addr0(addr0), .addr1(addr1),
        .wdata0(wdata0), .wdata1(wdata1), .pair_done(pair_done),
        .req_valid_0(req_valid_0), .req_addr_0(req_addr_0), .req_wdata_0(req_wdata_0),
        .req_strobe_0(req_strobe_0), .req_write_0(req_write_0),
        .req_valid_1(req_valid_1), .req_addr_1(req_addr_1), .req_wdata_1(req_wdata_1),
        .req_strobe_1(req_strobe_1), .req_write_1(req_write_1),
        .issue_pulse(issue_pulse), .lane_need0(lane_need0), .lane_need1(lane_need1),
        .ctx_size0(ctx_size0), .ctx_size1(ctx_size1),
        .ctx_sext0(ctx_sext0), .ctx_sext1(ctx_sext1),
        .ctx_off0(ctx_off0), .ctx_off1(ctx_off1),
        .ctx_op0(ctx_op0), .ctx_op1(ctx_op1),
        .ctx_mis0(ctx_mis0), .ctx_mis1(ctx_mis1)
    );

    data_ram #(
        .fast_latency(fast_latency),
        .slow_latency(slow_latency)
    ) u_ram (
        .clk(clk), .resetn(resetn),
        .req_valid_0(req_valid_0), .req_addr_0(req_addr_0), .req_wdata_0(req_wdata_0),
        .req_strobe_0(req_strobe_0), .req_write_0(req_write_0),
        .req_valid_1(req_valid_1), .req_addr_1(req_addr_1), .req_wdata_1(req_wdata_1),
        .req_strobe_1(req_strobe_1), .req_write_1(req_write_1),
        .resp_ok0(resp_ok0), .resp_ok1(resp_ok1),
        .resp_data0(resp_data0), .resp_data1(resp_data1)
    );

    resp_capture u_capture (
        .clk(clk), .resetn(resetn), .issue_pulse(issue_pulse),
        .lane_need0(lane_need0), .lane_need1(lane_need1),
        .resp_ok0(resp_ok0), .resp_ok1(resp_ok1),
        .resp_data0(resp_data0), .resp_data1(resp_data1),
        .out_ready(out_ready), .out_valid(out_valid), .pair_done(pair_done),
        .held_data0(held_data0), .held_data1(held_data1)
    );

    load_align u_align0 (
        .raw(held_data0), .off(ctx_off0), .size(ctx_size0), .sext(ctx_sext0),
        .rdata(aligned0)
    );

    load_align u_align1 (
        .raw(held_data1), .off(ctx_off1), .size(ctx_size1), .sext(ctx_sext1),
        .rdata(aligned1)
    );

    // only an aligned load carries data out
    assign rdata0 = (ctx_op0 == op_load && !ctx_mis0) ? aligned0 : '0;
    assign rdata1 = (ctx_op1 == op_load && !ctx_mis1) ? aligned1 : '0;

    assign misalign0 = ctx_mis0;
    assign misalign1 = ctx_mis1;
    assign op0_out   = ctx_op0;
    assign op1_out   = ctx_op1;

endmodule

`default_nettype wire

//--- hw/resp_capture.sv
`default_nettype none

module resp_capture (
    input  logic           clk,
    input  logic           resetn,
    input  logic           issue_pulse,
    input  logic           lane_need0,
    input  logic           lane_need1,
    input  logic           resp_ok0,
    input  logic           resp_ok1,
    input  mem_pkg::word_t resp_data0,
    input  mem_pkg::word_t resp_data1,
    input  logic           out_ready,
    output logic           out_valid,
    output logic           pair_done,
    output mem_pkg::word_t held_data0,
    output mem_pkg::word_t held_data1
);
    logic pend0;
    logic pend1;
    logic waiting;
    logic pend0_next;
    logic pend1_next;
    logic done_next;

    // pending state as it will be after this edge
    assign pend0_next = issue_pulse ? lane_need0 : (pend0 && !resp_ok0);
    assign pend1_next = issue_pulse ? lane_need1 : (pend1 && !resp_ok1);
    assign done_next  = (issue_pulse || waiting) && !pend0_next && !pend1_next;

    assign pair_done = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (resetn) begin
            pend0     <= 1'b0;
            pend1     <= 1'b0;
            waiting   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            pend0 <= pend0_next;
            pend1 <= pend1_next;
            if (done_next) begin
                waiting   <= 1'b0;
                out_valid <= 1'b1;
            end else begin
                if (issue_pulse) begin
                    waiting <= 1'b1;
                end
                if (pair_done) begin
                    out_valid <= 1'b0;
                end
            end
        end
    end

    // either lane may finish first, each keeps its own copy
    always_ff @(posedge clk) begin
        if (resp_ok0) begin
            held_data0 <= resp_data0;
        end
        if (resp_ok1) begin
            held_data1 <= resp_data1;
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the mem_stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
    -f compile.f --top-module mem_stage_tb -o sim

# the pipe keeps a crashed run from skipping the log search
./obj_dir/sim +verilator+error+limit+1000 | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "No errors" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

//--- tb/mem_stage_properties.sv
`default_nettype none

module mem_stage_properties (
    input wire logic             clk,
    input wire logic             resetn,
    input wire logic             in_valid,
    input wire logic             in_ready,
    input wire mem_pkg::mem_op_t op0,
    input wire mem_pkg::mem_op_t op1,
    input wire logic             out_valid,
    input wire logic             out_ready,
    input wire mem_pkg::word_t   rdata0,
    input wire mem_pkg::word_t   rdata1,
    input wire logic             misalign0,
    input wire logic             misalign1,
    input wire mem_pkg::mem_op_t op0_out,
    input wire mem_pkg::mem_op_t op1_out,
    input wire logic             req_valid_0,
    input wire logic             req_valid_1,
    input wire logic             issue_pulse,
    input wire logic             lane_need0,
    input wire logic             lane_need1,
    input wire logic             resp_ok0,
    input wire logic             resp_ok1
);
    timeunit 1ns;
    timeprecision 1ns;
    import mem_pkg::*;

    int   violations = 0;
    logic seen0;
    logic seen1;
    logic accept;
    logic xfer;

    assign accept = in_valid && in_ready;
    assign xfer   = out_valid && out_ready;

    // responses seen since the last issue
    always_ff @(posedge clk) begin
        if (resetn || issue_pulse) begin
            seen0 <= 1'b0;
            seen1 <= 1'b0;
        end else begin
            if (resp_ok0) begin
                seen0 <= 1'b1;
            end
            if (resp_ok1) begin
                seen1 <= 1'b1;
            end
        end
    end

    a_reset_state: assert property (@(posedge clk) $fell(resetn) |-> in_ready && !out_valid)
        else begin $error("state after reset is wrong"); violations++; end

    a_hold: assert property (@(posedge clk) disable iff (resetn)
        out_valid && !out_ready |=> out_valid && $stable(rdata0) && $stable(rdata1)
            && $stable(misalign0) && $stable(misalign1) && $stable(op0_out) && $stable(op1_out))
        else begin $error("output changed under back-pressure"); violations++; end

    a_busy_on_accept: assert property (@(posedge clk) disable iff (resetn)
        accept |=> !in_ready)
        else begin $error("in_ready high after acceptance"); violations++; end

    a_busy_hold: assert property (@(posedge clk) disable iff (resetn)
        !in_ready && !xfer |=> !in_ready)
        else begin $error("in_ready rose before output transfer"); violations++; end

    a_free_after_xfer: assert property (@(posedge clk) disable iff (resetn)
        xfer |=> in_ready)
        else begin $error("in_ready low after output transfer"); violations++; end

    // requests only in the cycle after acceptance
    a_req_window: assert property (@(posedge clk) disable iff (resetn)
        (req_valid_0 || req_valid_1) |-> $past(accept))
        else begin $error("ram request outside the issue cycle"); violations++; end

    a_out_after_resp: assert property (@(posedge clk) disable iff (resetn)
        $rose(out_valid) |-> (!lane_need0 || seen0) && (!lane_need1 || seen1))
        else begin $error("out_valid rose before all responses"); violations++; end

    a_none_pair: assert property (@(posedge clk) disable iff (resetn)
        accept && op0 == op_none && op1 == op_none
            |=> !req_valid_0 && !req_valid_1 && !out_valid ##1 out_valid)
        else begin $error("pass-through pair timing is wrong"); violations++; end

endmodule

`default_nettype wire

//--- tb/mem_stage_tb.sv
`default_nettype none

module mem_stage_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import mem_pkg::*;

    localparam int fast_latency = 1;
    localparam int slow_latency = 3;
    localparam int n_pairs = 400;
    localparam int n_init = 4;
    // slowest pair plus stall slack, and the reset cycles
    localparam int cycle_limit = n_pairs * (slow_latency + 6) + 10;

    logic    clk = 1'b0;
    logic    resetn;
    logic    in_valid;
    logic    in_ready;
    mem_op_t op0;
    mem_op_t op1;
    msize_t  size0;
    msize_t  size1;
    logic    sext0;
    logic    sext1;
    word_t   addr0;
    word_t   addr1;
    word_t   wdata0;
    word_t   wdata1;
    logic    out_valid;
    logic    out_ready;
    word_t   rdata0;
    word_t   rdata1;
    logic    misalign0;
    logic    misalign1;
    mem_op_t op0_out;
    mem_op_t op1_out;

    logic [31:0] lfsr = 32'h4f74;
    word_t       shadow [256];
    word_t       bases [8];
    int          value_errors = 0;
    int          protocol_errors;
    int          cycles = 0;

    // next pair to drive, and what it should return
    mem_op_t p_op [2];
    msize_t  p_size [2];
    logic    p_sext [2];
    word_t   p_addr [2];
    word_t   p_wdata [2];
    word_t   exp_rdata [2];
    logic    exp_mis [2];

    mem_stage #(
        .fast_latency(fast_latency),
        .slow_latency(slow_latency)
    ) mem_stage_i (
        .clk(clk), .resetn(resetn), .in_valid(in_valid), .in_ready(in_ready),
        .op0(op0), .op1(op1), .size0(size0), .size1(size1),
        .sext0(sext0), .sext1(sext1), .addr0(addr0), .addr1(addr1),
        .wdata0(wdata0), .wdata1(wdata1),
        .out_valid(out_valid), .out_ready(out_ready),
        .rdata0(rdata0), .rdata1(rdata1), .misalign0(misalign0), .misalign1(misalign1),
        .op0_out(op0_out), .op1_out(op1_out)
    );

    bind mem_stage mem_stage_properties props_i (
        .clk(clk), .resetn(resetn), .in_valid(in_valid), .in_ready(in_ready),
        .op0(op0), .op1(op1), .out_valid(out_valid), .out_ready(out_ready),
        .rdata0(rdata0), .rdata1(rdata1), .misalign0(misalign0), .misalign1(misalign1),
        .op0_out(op0_out), .op1_out(op1_out),
        .req_valid_0(req_valid_0), .req_valid_1(req_valid_1),
        .issue_pulse(issue_pulse), .lane_need0(lane_need0), .lane_need1(lane_need1),
        .resp_ok0(resp_ok0), .resp_ok1(resp_ok1)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic word_t fill_word(word_t addr);
        return (addr * 32'h9e37_79b9) ^ {addr[15:0], ~addr[15:0]};
    endfunction

    function automatic int size_bytes(msize_t size);
        return (size == sz_byte) ? 1 : (size == sz_half) ? 2 : 4;
    endfunction

    function automatic word_t load_value(word_t w, logic [1:0] off, msize_t size, logic sext);
        word_t v;
        int    n;
        v = '0;
        n = size_bytes(size);
        for (int k = 0; k < n; k++) begin
            v[8*k +: 8] = w[8*(int'(off)+k) +: 8];
        end
        if (sext && n < 4 && v[8*n-1]) begin
            for (int k = n; k < 4; k++) begin
                v[8*k +: 8] = 8'hff;
            end
        end
        return v;
    endfunction

    function automatic word_t store_merge(word_t old, word_t d, logic [1:0] off, msize_t size);
        word_t res;
        res = old;
        for (int k = 0; k < size_bytes(size); k++) begin
            res[8*(int'(off)+k) +: 8] = d[8*k +: 8];
        end
        return res;
    endfunction

    // shadow memory step for one lane, lane 0 goes first
    task automatic model_lane(int lane);
        int   idx;
        logic mis;
        idx = int'(p_addr[lane][9:2]);
        mis = p_op[lane] != op_none && ((p_size[lane] == sz_half && p_addr[lane][0])
            || (p_size[lane] == sz_word && p_addr[lane][1:0] != 2'b00));
        exp_mis[lane]   = mis;
        exp_rdata[lane] = '0;
        if (!mis && p_op[lane] == op_load) begin
            exp_rdata[lane] = load_value(shadow[idx], p_addr[lane][1:0], p_size[lane],
                p_sext[lane]);
        end else if (!mis && p_op[lane] == op_store) begin
            shadow[idx] = store_merge(shadow[idx], p_wdata[lane], p_addr[lane][1:0],
                p_size[lane]);
        end
    endtask

    task automatic check_value(string name, word_t expected, word_t actual);
        assert (actual === expected) else begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic set_lane(int lane, mem_op_t op, msize_t size, logic sext, word_t addr,
                            word_t wdata);
        p_op[lane]    = op;
        p_size[lane]  = size;
        p_sext[lane]  = sext;
        p_addr[lane]  = addr;
        p_wdata[lane] = wdata;
    endtask

    task automatic random_lane(int lane);
        logic [1:0] r_op;
        logic [1:0] r_size;
        mem_op_t    op;
        msize_t     size;
        word_t      addr;
        r_op   = 2'(take_bits(2));
        r_size = 2'(take_bits(2));
        op     = (r_op == 2'd0) ? op_none : (r_op == 2'd2) ? op_store : op_load;
        size   = (r_size == 2'd1) ? sz_half : (r_size == 2'd2) ? sz_word : sz_byte;
        addr   = bases[3'(take_bits(3))] | word_t'(take_bits(2));
        set_lane(lane, op, size, take_bits(1) != 0, addr, take_bits(32));
    endtask

    task automatic run_pair(int num);
        string tag;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        op0 = p_op[0];
        size0 = p_size[0];
        sext0 = p_sext[0];
        addr0 = p_addr[0];
        wdata0 = p_wdata[0];
        op1 = p_op[1];
        size1 = p_size[1];
        sext1 = p_sext[1];
        addr1 = p_addr[1];
        wdata1 = p_wdata[1];
        in_valid = 1'b1;
        model_lane(0);
        model_lane(1);
        // stall out_ready about one cycle in four
        do begin
            @(negedge clk);
            in_valid  = 1'b0;
            out_ready = take_bits(2) != 32'd0;
        end while (!(out_valid && out_ready));
        tag = $sformatf("pair %0d", num);
        check_value({tag, " rdata0"}, exp_rdata[0], rdata0);
        check_value({tag, " rdata1"}, exp_rdata[1], rdata1);
        check_value({tag, " misalign0"}, 32'(exp_mis[0]), 32'(misalign0));
        check_value({tag, " misalign1"}, 32'(exp_mis[1]), 32'(misalign1));
        check_value({tag, " op0_out"}, 32'(p_op[0]), 32'(op0_out));
        check_value({tag, " op1_out"}, 32'(p_op[1]), 32'(op1_out));
    endtask

    initial begin
        resetn = 1'b1;
        in_valid = 1'b0;
        out_ready = 1'b0;
        op0 = op_none;
        op1 = op_none;
        size0 = sz_byte;
        size1 = sz_byte;
        sext0 = 1'b0;
        sext1 = 1'b0;
        addr0 = '0;
        addr1 = '0;
        wdata0 = '0;
        wdata1 = '0;
        // fast and slow words, some alias the same ram word
        bases = '{32'h0040, 32'h0044, 32'h0048, 32'h0100,
                  32'h1040, 32'h1048, 32'h104c, 32'h1200};
        repeat (2) @(negedge clk);
        resetn = 1'b0;

        for (int i = 0; i < n_init; i++) begin
            set_lane(0, op_store, sz_word, 1'b0, bases[2*i], fill_word(bases[2*i]));
            set_lane(1, op_store, sz_word, 1'b0, bases[2*i+1], fill_word(bases[2*i+1]));
            run_pair(i);
        end
        set_lane(0, op_none, sz_word, 1'b0, bases[0], '0);
        set_lane(1, op_none, sz_word, 1'b0, bases[4], '0);
        run_pair(n_init);
        for (int i = n_init + 1; i < n_pairs; i++) begin
            random_lane(0);
            random_lane(1);
            run_pair(i);
        end

        repeat (2) @(negedge clk);
        protocol_errors = mem_stage_i.props_i.violations;
        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
